/* Bender.yml */
package:
  name: alu8

sources:
  - rtl/alu_pkg.sv
  - rtl/alu_status_pkg.sv
  - rtl/sm_unit.sv
  - rtl/tc_unit.sv
  - rtl/alu_out_stage.sv
  - rtl/alu_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/alu_checker.sv
      - verif/tb_alu.sv

/* project.f */
rtl/alu_pkg.sv
rtl/alu_status_pkg.sv
rtl/sm_unit.sv
rtl/tc_unit.sv
rtl/alu_out_stage.sv
rtl/alu_top.sv
verif/tb_clock.sv
verif/alu_checker.sv
verif/tb_alu.sv

/* rtl/alu_out_stage.sv */
`timescale 1ns/1ps

module alu_out_stage (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  alu_pkg::alu_op_t              i_op,
	input  alu_pkg::unit_out_t            i_sm,
	input  alu_pkg::unit_out_t            i_tc,
	output logic [alu_pkg::WORD_W-1:0]    o_result,
	output alu_status_pkg::alu_status_t   o_status,
	output logic                          o_op_rdy,
	output logic                          o_alu_error
);

	import alu_pkg::*;
	import alu_status_pkg::*;

	// Output of the unit picked by the group code
	unit_out_t sel;
	logic grp_bad;
	logic err_next;
	logic [WORD_W-1:0] res_next;
	logic [ST_W-1:0] flags;
	alu_status_t st_next;

	always_comb begin
		sel = '0;
		grp_bad = 1'b0;

		case (i_op.grp)
			GRP_SM: sel = i_sm;
			GRP_TC: sel = i_tc;
			// Remaining groups are not implemented
			default: grp_bad = 1'b1;
		endcase

		err_next = sel.err | grp_bad;
		// Any error forces a zero result
		res_next = err_next ? '0 : sel.result;

		// Zero and parity come from the result after zeroing
		flags = '0;
		flags[ST_ERR] = err_next;
		flags[ST_ZERO] = (res_next == '0);
		flags[ST_PAR] = ^res_next;
		flags[ST_OVF] = sel.ovf;
		st_next = alu_status_t'(flags);
	end

	// Single register stage for all outputs
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			o_result <= '0;
			o_status <= '0;
			o_op_rdy <= 1'b0;
			o_alu_error <= 1'b0;
		end else begin
			o_result <= res_next;
			o_status <= st_next;
			o_op_rdy <= !st_next.err;
			o_alu_error <= st_next.err;
		end
	end

	// Ready and error levels are exclusive
	a_rdy_err_excl: assert property (@(posedge i_clk) disable iff (!i_reset)
		!(o_op_rdy && o_alu_error));

	// Error flag always comes with a zero result
	a_err_zero: assert property (@(posedge i_clk) disable iff (!i_reset)
		o_status[ST_ERR] |-> (o_result == '0));

	// Cycle after a reset edge everything is cleared
	a_reset_clear: assert property (@(posedge i_clk)
		!i_reset |=> (o_result == '0) && (o_status == '0) && !o_op_rdy && !o_alu_error);

endmodule

/* rtl/alu_pkg.sv */
package alu_pkg;

	// Operand and result width
	localparam int WORD_W = 8;

	// Magnitude part of a sign-magnitude word
	localparam int MAG_W = WORD_W - 1;

	// Operation code width, group in the upper half
	localparam int OP_W = 4;

	// Group codes
	localparam logic [1:0] GRP_SM = 2'b00;
	localparam logic [1:0] GRP_TC = 2'b01;

	// Sign-magnitude group functions
	localparam logic [1:0] FN_SHR   = 2'b00;
	localparam logic [1:0] FN_ADD   = 2'b01;
	localparam logic [1:0] FN_DIV   = 2'b10;
	localparam logic [1:0] FN_TO_TC = 2'b11;

	// Two's-complement group functions
	localparam logic [1:0] FN_SUB2    = 2'b00;
	localparam logic [1:0] FN_LT      = 2'b01;
	localparam logic [1:0] FN_TO_SM   = 2'b10;
	localparam logic [1:0] FN_ADD_CLR = 2'b11;

	// Operation code, group in bits 3:2, function in bits 1:0
	typedef struct packed {
		logic [1:0] grp;
		logic [1:0] fn;
	} alu_op_t;

	// Sign bit on top of the magnitude
	typedef struct packed {
		logic             sign;
		logic [MAG_W-1:0] mag;
	} sm_word_t;

	// One operand word, read either as sign-magnitude or as signed
	typedef union packed {
		sm_word_t                  sm;
		logic signed [WORD_W-1:0] tc;
	} alu_word_u;

	// What each arithmetic unit hands to the output stage
	typedef struct packed {
		logic [WORD_W-1:0] result;
		logic              ovf;
		logic              err;
	} unit_out_t;

endpackage

/* rtl/alu_status_pkg.sv */
package alu_status_pkg;

	// Flag positions inside the status word
	localparam int ST_ERR  = 0;
	localparam int ST_ZERO = 1;
	localparam int ST_PAR  = 2;
	localparam int ST_OVF  = 3;

	// Width of the status word
	localparam int ST_W = 4;

	// Status word
	// Field order follows the positions above, overflow on top
	typedef struct packed {
		// Result did not fit
		logic ovf;
		// Odd count of ones in the result
		logic par;
		// Result is all zeros
		logic zero;
		// Operation could not be done
		logic err;
	} alu_status_t;

endpackage

/* rtl/alu_top.sv */
`timescale 1ns/1ps

module alu_top (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  logic [alu_pkg::OP_W-1:0]   i_op,
	input  logic [alu_pkg::WORD_W-1:0] i_arg_a,
	input  logic [alu_pkg::WORD_W-1:0] i_arg_b,
	output logic [alu_pkg::WORD_W-1:0] o_result,
	output logic [3:0]                 o_status,
	output logic                       o_op_rdy,
	output logic                       o_alu_error
);

	import alu_pkg::*;

	// Operation code split into group and function
	alu_op_t op;

	// Operands, each unit picks its own view
	alu_word_u arg_a;
	alu_word_u arg_b;

	// Unit results into the output stage
	unit_out_t sm_out;
	unit_out_t tc_out;

	assign op = alu_op_t'(i_op);
	assign arg_a = alu_word_u'(i_arg_a);
	assign arg_b = alu_word_u'(i_arg_b);

	// Sign-magnitude group
	sm_unit u_sm_unit (
		.i_op    (op),
		.i_arg_a (arg_a),
		.i_arg_b (arg_b),
		.o_out   (sm_out)
	);

	// Two's-complement group
	tc_unit u_tc_unit (
		.i_op    (op),
		.i_arg_a (arg_a),
		.i_arg_b (arg_b),
		.o_out   (tc_out)
	);

	// Group select, flags and the output register
	alu_out_stage u_alu_out_stage (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_op        (op),
		.i_sm        (sm_out),
		.i_tc        (tc_out),
		.o_result    (o_result),
		.o_status    (o_status),
		.o_op_rdy    (o_op_rdy),
		.o_alu_error (o_alu_error)
	);

endmodule

/* rtl/sm_unit.sv */
`timescale 1ns/1ps

module sm_unit (
	input  alu_pkg::alu_op_t   i_op,
	input  alu_pkg::alu_word_u i_arg_a,
	input  alu_pkg::alu_word_u i_arg_b,
	output alu_pkg::unit_out_t o_out
);

	import alu_pkg::*;

	// Operands in sign-magnitude view
	sm_word_t a;
	sm_word_t b;

	// Whole word of A for the shift
	logic [WORD_W-1:0] a_word;

	// Magnitude sum with carry bit
	logic [MAG_W:0] mag_sum;

	// Magnitude quotient
	logic [MAG_W-1:0] mag_quot;

	assign a = i_arg_a.sm;
	assign b = i_arg_b.sm;
	assign a_word = a;

	always_comb begin
		o_out = '0;
		mag_sum = {1'b0, a.mag} + {1'b0, b.mag};
		mag_quot = '0;

		case (i_op.fn)
			FN_SHR: begin
				// Shift amount must be non-negative
				if (b.sign) begin
					o_out.err = 1'b1;
				end else if (b.mag >= MAG_W'(WORD_W)) begin
					// Everything shifted out
					o_out.result = '0;
				end else begin
					o_out.result = a_word >> b.mag;
				end
			end

			FN_ADD: begin
				if (a.sign == b.sign) begin
					// Same signs, magnitudes add up
					if (mag_sum[MAG_W]) begin
						o_out.err = 1'b1;
						o_out.ovf = 1'b1;
					end else begin
						o_out.result = {a.sign, mag_sum[MAG_W-1:0]};
					end
				end else if (a.mag > b.mag) begin
					// Larger magnitude decides the sign
					o_out.result = {a.sign, a.mag - b.mag};
				end else if (b.mag > a.mag) begin
					o_out.result = {b.sign, b.mag - a.mag};
				end else begin
					// Opposite values cancel to +0
					o_out.result = '0;
				end
			end

			FN_DIV: begin
				if (b.mag == '0) begin
					// Divide by zero, either sign
					o_out.err = 1'b1;
				end else begin
					mag_quot = a.mag / b.mag;
					// Zero quotient never carries a sign
					if (mag_quot == '0) begin
						o_out.result = '0;
					end else begin
						o_out.result = {a.sign ^ b.sign, mag_quot};
					end
				end
			end

			FN_TO_TC: begin
				// Positive values are the same in both codes
				if (!a.sign) begin
					o_out.result = a_word;
				end else begin
					// Negate the magnitude, -0 lands on 0
					o_out.result = -{1'b0, a.mag};
				end
			end

			default: begin
				o_out = '0;
			end
		endcase
	end

endmodule

/* rtl/tc_unit.sv */
`timescale 1ns/1ps

module tc_unit (
	input  alu_pkg::alu_op_t   i_op,
	input  alu_pkg::alu_word_u i_arg_a,
	input  alu_pkg::alu_word_u i_arg_b,
	output alu_pkg::unit_out_t o_out
);

	import alu_pkg::*;

	// Operands in signed view
	logic signed [WORD_W-1:0] a;
	logic signed [WORD_W-1:0] b;

	// Sign-extended copies, two guard bits cover 2*B
	logic signed [WORD_W+1:0] a_x;
	logic signed [WORD_W+1:0] b_x;

	// Wide arithmetic results
	logic signed [WORD_W+1:0] diff;
	logic signed [WORD_W+1:0] sum;

	// Sum narrowed back to a word before the bit clear
	logic [WORD_W-1:0] sum_w;

	// Negated A for conversion
	logic [WORD_W-1:0] neg_a;

	// Out of word range when the guard bits differ from the word sign
	logic diff_oor;
	logic sum_oor;

	assign a = i_arg_a.tc;
	assign b = i_arg_b.tc;
	assign a_x = a;
	assign b_x = b;

	assign diff = a_x - (b_x + b_x);
	assign sum = a_x + b_x;
	assign diff_oor = (diff[WORD_W+1:WORD_W-1] != {3{diff[WORD_W-1]}});
	assign sum_oor = (sum[WORD_W+1:WORD_W-1] != {3{sum[WORD_W-1]}});
	assign neg_a = -a;

	always_comb begin
		o_out = '0;
		sum_w = sum[WORD_W-1:0];

		case (i_op.fn)
			FN_SUB2: begin
				if (diff_oor) begin
					o_out.err = 1'b1;
					o_out.ovf = 1'b1;
				end else begin
					o_out.result = diff[WORD_W-1:0];
				end
			end

			FN_LT: begin
				// Signed compare, result is 0 or 1
				o_out.result = {{(WORD_W-1){1'b0}}, a < b};
			end

			FN_TO_SM: begin
				if (a == {1'b1, {MAG_W{1'b0}}}) begin
					// -128 has no sign-magnitude form
					o_out.err = 1'b1;
					o_out.ovf = 1'b1;
				end else if (a[WORD_W-1]) begin
					o_out.result = {1'b1, neg_a[MAG_W-1:0]};
				end else begin
					o_out.result = a;
				end
			end

			FN_ADD_CLR: begin
				if (sum_oor) begin
					o_out.err = 1'b1;
					o_out.ovf = 1'b1;
				end else begin
					// Low three bits of B pick the bit to clear
					sum_w[b[2:0]] = 1'b0;
					o_out.result = sum_w;
				end
			end

			default: begin
				o_out = '0;
			end
		endcase
	end

endmodule

/* verif/alu_checker.sv */
`timescale 1ns/1ps

module alu_checker (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  logic [alu_pkg::OP_W-1:0]   i_op,
	input  logic [alu_pkg::WORD_W-1:0] i_arg_a,
	input  logic [alu_pkg::WORD_W-1:0] i_arg_b,
	input  logic [alu_pkg::WORD_W-1:0] i_result,
	input  logic [3:0]                 i_status,
	input  logic                       i_op_rdy,
	input  logic                       i_alu_error,
	output int                         o_errors,
	output int                         o_checks
);

	import alu_pkg::*;
	import alu_status_pkg::*;

	// Expected register contents after one edge
	typedef struct packed {
		logic [WORD_W-1:0] result;
		logic [ST_W-1:0]   status;
		logic              rdy;
		logic              err;
	} expect_t;

	int errors = 0;
	int checks = 0;

	// Nothing to compare before the first edge
	logic have_expect = 1'b0;
	expect_t exp_q;

	// Inputs behind the value now under comparison
	logic [OP_W-1:0] last_op;
	logic [WORD_W-1:0] last_a;
	logic [WORD_W-1:0] last_b;

	assign o_errors = errors;
	assign o_checks = checks;

	// Reference model worked out on plain integers
	function automatic expect_t model_expect(input logic [OP_W-1:0] op,
			input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b);
		int ma;
		int mb;
		int ia;
		int ib;
		int v;
		logic [WORD_W-1:0] res;
		logic err;
		logic ovf;
		expect_t e;
		res = '0;
		err = 1'b0;
		ovf = 1'b0;
		v = 0;
		// Magnitudes unsigned, whole words sign-extended
		ma = a[6:0];
		mb = b[6:0];
		ia = $signed(a);
		ib = $signed(b);
		if (op[3:2] == GRP_SM) begin
			case (op[1:0])
				FN_SHR: begin
					if (b[7]) err = 1'b1;
					else if (mb >= 8) res = '0;
					else res = a >> mb;
				end
				FN_ADD: begin
					if (a[7] == b[7]) begin
						v = ma + mb;
						if (v > 127) begin
							err = 1'b1;
							ovf = 1'b1;
						end else begin
							res = {a[7], v[6:0]};
						end
					end else if (ma > mb) begin
						v = ma - mb;
						res = {a[7], v[6:0]};
					end else if (mb > ma) begin
						v = mb - ma;
						res = {b[7], v[6:0]};
					end
				end
				FN_DIV: begin
					if (mb == 0) begin
						err = 1'b1;
					end else begin
						v = ma / mb;
						// A zero quotient is +0
						if (v != 0) res = {a[7] ^ b[7], v[6:0]};
					end
				end
				default: begin
					v = a[7] ? -ma : ma;
					res = v[7:0];
				end
			endcase
		end else if (op[3:2] == GRP_TC) begin
			case (op[1:0])
				FN_SUB2: begin
					v = ia - 2 * ib;
					if (v < -128 || v > 127) begin
						err = 1'b1;
						ovf = 1'b1;
					end else begin
						res = v[7:0];
					end
				end
				FN_LT: res = (ia < ib) ? 8'd1 : 8'd0;
				FN_TO_SM: begin
					if (ia == -128) begin
						err = 1'b1;
						ovf = 1'b1;
					end else if (ia < 0) begin
						v = -ia;
						res = {1'b1, v[6:0]};
					end else begin
						res = a;
					end
				end
				default: begin
					v = ia + ib;
					if (v < -128 || v > 127) begin
						err = 1'b1;
						ovf = 1'b1;
					end else begin
						res = v[7:0];
						res[b[2:0]] = 1'b0;
					end
				end
			endcase
		end else begin
			// Dropped and unused groups
			err = 1'b1;
		end
		if (err) res = '0;
		e.result = res;
		e.status = '0;
		e.status[ST_ERR] = err;
		e.status[ST_ZERO] = (res == '0);
		e.status[ST_PAR] = ^res;
		e.status[ST_OVF] = ovf;
		e.rdy = !err;
		e.err = err;
		return e;
	endfunction

	task automatic compare_field(input string field, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] want);
		if (got !== want) begin
			errors++;
			$display("Fail at %0d ns: %s is %h, expected %h (op %h a %h b %h)",
				$time, field, got, want, last_op, last_a, last_b);
		end
	endtask

	// Outputs seen at an edge still hold what the previous edge registered
	always @(posedge i_clk) begin
		if (have_expect) begin
			checks++;
			compare_field("result", i_result, exp_q.result);
			compare_field("status", {4'b0, i_status}, {4'b0, exp_q.status});
			compare_field("op_rdy", {7'b0, i_op_rdy}, {7'b0, exp_q.rdy});
			compare_field("alu_error", {7'b0, i_alu_error}, {7'b0, exp_q.err});
		end
		last_op = i_op;
		last_a = i_arg_a;
		last_b = i_arg_b;
		// Reset edge clears every output
		if (!i_reset) exp_q = '0;
		else exp_q = model_expect(i_op, i_arg_a, i_arg_b);
		have_expect = 1'b1;
	end

endmodule

/* verif/tb_alu.sv */
`timescale 1ns/1ps

module tb_alu;

	import alu_pkg::*;

	localparam int N_OPS = 2000;
	localparam int RESET_CYCLES = 4;
	localparam int MARGIN_CYCLES = 20;
	localparam int CLK_PERIOD = 10;
	localparam logic [31:0] SEED = 32'ha3a2_6bf2;
	// Taps of x^32 + x^22 + x^2 + x + 1 in right-shifting form
	localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

	logic clk;
	logic reset;
	logic [OP_W-1:0] op;
	logic [WORD_W-1:0] arg_a;
	logic [WORD_W-1:0] arg_b;
	logic [WORD_W-1:0] result;
	logic [3:0] status;
	logic op_rdy;
	logic alu_error;
	int errors;
	int checks;
	logic [31:0] lfsr;

	tb_clock u_tb_clock (
		.o_clk   (clk),
		.o_reset (reset)
	);

	alu_top DUT (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_op        (op),
		.i_arg_a     (arg_a),
		.i_arg_b     (arg_b),
		.o_result    (result),
		.o_status    (status),
		.o_op_rdy    (op_rdy),
		.o_alu_error (alu_error)
	);

	alu_checker u_alu_checker (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_op        (op),
		.i_arg_a     (arg_a),
		.i_arg_b     (arg_b),
		.i_result    (result),
		.i_status    (status),
		.i_op_rdy    (op_rdy),
		.i_alu_error (alu_error),
		.o_errors    (errors),
		.o_checks    (checks)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return (state >> 1) ^ (state[0] ? LFSR_POLY : 32'h0);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] val);
		logic [31:0] acc;
		acc = '0;
		for (int k = 0; k < n; k++) begin
			acc = {acc[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		val = acc;
	endtask

	// Operands that hit -0, -128, zero divisors, wide shifts and overflow
	function automatic logic [WORD_W-1:0] corner_value(input logic [2:0] sel);
		case (sel)
			3'd0: return 8'h00;
			3'd1: return 8'h80;
			3'd2: return 8'h7f;
			3'd3: return 8'hff;
			3'd4: return 8'h01;
			3'd5: return 8'h81;
			3'd6: return 8'h08;
			default: return 8'hc0;
		endcase
	endfunction

	task automatic drive_operation(input int n);
		logic [31:0] r;
		logic [31:0] mix;
		take_bits(OP_W, r);
		take_bits(1, mix);
		op = r[OP_W-1:0];
		// Half the illegal groups fold back onto the two kept ones
		if (mix[0]) op[3] = 1'b0;
		// First sweep walks every opcode once in order
		if (n >= RESET_CYCLES && n < RESET_CYCLES + 16) op = 4'(n - RESET_CYCLES);
		take_bits(WORD_W, r);
		arg_a = r[WORD_W-1:0];
		take_bits(WORD_W, r);
		arg_b = r[WORD_W-1:0];
		if (n % 4 == 3) begin
			take_bits(4, r);
			if (r[3]) arg_a = corner_value(r[2:0]);
			else arg_b = corner_value(r[2:0]);
		end else if (n % 8 == 5) begin
			// Same magnitude with the other sign
			arg_b = arg_a ^ 8'h80;
		end
	endtask

	initial begin
		op = '0;
		arg_a = '0;
		arg_b = '0;
		lfsr = SEED;
		for (int n = 0; n < N_OPS + RESET_CYCLES; n++) begin
			@(posedge clk);
			#1;
			drive_operation(n);
		end
		// Last operation is registered and then compared one edge later
		repeat (2) @(posedge clk);
		#1;
		$display("Checked %0d cycles, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog sized from the test length
	initial begin
		#((N_OPS + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d ns",
			(N_OPS + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk,
	output logic o_reset
);

	// 10 ns period
	localparam int HALF_PERIOD = 5;

	// Number of rising edges that see reset low
	localparam int RESET_CYCLES = 4;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// Release shortly after the last reset edge, like all other inputs
	initial begin
		o_reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1;
		o_reset = 1'b1;
	end

endmodule
